//--- common/eth_tx_pkg.sv
// Shared types, frame size constants and state encodings for the Ethernet
// transmit path. Modules refer to these by scoped name.

`default_nettype none

package eth_tx_pkg;

    // stream byte and header fields
    typedef logic [7:0] eth_byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] eth_type_t;

    // running CRC-32 value
    typedef logic [31:0] crc_t;

    // dest + src + ethertype
    localparam int HDR_LEN = 14;

    // shortest frame on the wire, not counting the FCS
    localparam int MIN_FRAME_LEN = 60;

    localparam int FCS_LEN = 4;

    // reflected IEEE 802.3 polynomial, bytes shifted in lsb first
    localparam crc_t CRC_POLY = 32'hEDB8_8320;
    localparam crc_t CRC_INIT = 32'hFFFF_FFFF;

    // header framer states
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_WRITE_HEADER,
        TX_WRITE_PAYLOAD
    } tx_state_t;

    // pad / FCS inserter states
    typedef enum logic [1:0] {
        ST_PAYLOAD,
        ST_PAD,
        ST_FCS
    } fcs_state_t;

endpackage

`default_nettype wire

//--- eth_axis_tx/eth_axis_tx.sv
// Ethernet header framer. Takes dest/src MAC and ethertype in one handshake,
// sends the 14 header bytes msb first, then passes the payload stream through.
// The output goes through a register plus skid register for full throughput.

`timescale 1ns/10ps
`default_nettype none

module eth_axis_tx (
    input  wire                    clk,
    input  wire                    rst,

    input  wire                    hdr_valid,
    output logic                   hdr_ready,
    input  wire eth_tx_pkg::mac_addr_t dest_mac,
    input  wire eth_tx_pkg::mac_addr_t src_mac,
    input  wire eth_tx_pkg::eth_type_t eth_type,

    input  wire eth_tx_pkg::eth_byte_t pay_data,
    input  wire                    pay_valid,
    output logic                   pay_ready,
    input  wire                    pay_last,
    input  wire                    pay_user,

    output eth_tx_pkg::eth_byte_t  m_data,
    output logic                   m_valid,
    input  wire                    m_ready,
    output logic                   m_last,
    output logic                   m_user,

    output logic                   busy
);

    eth_tx_pkg::tx_state_t state, state_next;

    // index of the next header byte to send
    logic [3:0] frame_ptr, frame_ptr_next;

    logic store_hdr;
    logic [8*eth_tx_pkg::HDR_LEN-1:0] hdr_reg;

    logic hdr_ready_next;
    logic pay_ready_next;

    // stage input, feeds the output register / skid pair
    eth_tx_pkg::eth_byte_t m_data_int;
    logic m_valid_int;
    logic m_last_int;
    logic m_user_int;
    logic m_ready_int_reg;
    logic m_ready_int_early;

    eth_tx_pkg::eth_byte_t temp_data;
    logic temp_valid, temp_valid_next;
    logic temp_last;
    logic temp_user;
    logic m_valid_next;

    logic store_int_to_output;
    logic store_int_to_temp;
    logic store_temp_to_output;

    always_comb begin
        state_next = state;
        frame_ptr_next = frame_ptr;
        hdr_ready_next = 1'b0;
        pay_ready_next = 1'b0;
        store_hdr = 1'b0;

        m_data_int = '0;
        m_valid_int = 1'b0;
        m_last_int = 1'b0;
        m_user_int = 1'b0;

        case (state)
            eth_tx_pkg::TX_IDLE: begin
                frame_ptr_next = '0;
                hdr_ready_next = 1'b1;
                if (hdr_ready && hdr_valid) begin
                    store_hdr = 1'b1;
                    hdr_ready_next = 1'b0;
                    // first dest byte can go straight from the ports
                    if (m_ready_int_reg) begin
                        m_valid_int = 1'b1;
                        m_data_int = dest_mac[47:40];
                        frame_ptr_next = 4'd1;
                    end
                    state_next = eth_tx_pkg::TX_WRITE_HEADER;
                end
            end
            eth_tx_pkg::TX_WRITE_HEADER: begin
                if (m_ready_int_reg) begin
                    m_valid_int = 1'b1;
                    m_data_int = hdr_reg[8*(eth_tx_pkg::HDR_LEN-1-int'(frame_ptr)) +: 8];
                    frame_ptr_next = frame_ptr + 4'd1;
                    if (frame_ptr == 4'(eth_tx_pkg::HDR_LEN - 1)) begin
                        pay_ready_next = m_ready_int_early;
                        state_next = eth_tx_pkg::TX_WRITE_PAYLOAD;
                    end
                end
            end
            eth_tx_pkg::TX_WRITE_PAYLOAD: begin
                pay_ready_next = m_ready_int_early;
                m_data_int = pay_data;
                m_valid_int = pay_valid && pay_ready;
                m_last_int = pay_last;
                m_user_int = pay_user;
                if (pay_ready && pay_valid && pay_last) begin
                    pay_ready_next = 1'b0;
                    hdr_ready_next = 1'b1;
                    state_next = eth_tx_pkg::TX_IDLE;
                end
            end
            default: begin
                state_next = eth_tx_pkg::TX_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= eth_tx_pkg::TX_IDLE;
            frame_ptr <= '0;
            hdr_ready <= 1'b0;
            pay_ready <= 1'b0;
            busy <= 1'b0;
        end else begin
            state <= state_next;
            frame_ptr <= frame_ptr_next;
            hdr_ready <= hdr_ready_next;
            pay_ready <= pay_ready_next;
            busy <= (state_next != eth_tx_pkg::TX_IDLE);
        end
    end

    // header fields held for the whole frame
    always_ff @(posedge clk) begin
        if (store_hdr) begin
            hdr_reg <= {dest_mac, src_mac, eth_type};
        end
    end

    // ready next cycle unless the skid would fill up
    assign m_ready_int_early = m_ready || (!temp_valid && (!m_valid || !m_valid_int));

    always_comb begin
        m_valid_next = m_valid;
        temp_valid_next = temp_valid;
        store_int_to_output = 1'b0;
        store_int_to_temp = 1'b0;
        store_temp_to_output = 1'b0;

        if (m_ready_int_reg) begin
            if (m_ready || !m_valid) begin
                m_valid_next = m_valid_int;
                store_int_to_output = 1'b1;
            end else begin
                // output stalled, park the byte in the skid register
                temp_valid_next = m_valid_int;
                store_int_to_temp = 1'b1;
            end
        end else if (m_ready) begin
            m_valid_next = temp_valid;
            temp_valid_next = 1'b0;
            store_temp_to_output = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid <= 1'b0;
            temp_valid <= 1'b0;
            m_ready_int_reg <= 1'b0;
        end else begin
            m_valid <= m_valid_next;
            temp_valid <= temp_valid_next;
            m_ready_int_reg <= m_ready_int_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_int_to_output) begin
            m_data <= m_data_int;
            m_last <= m_last_int;
            m_user <= m_user_int;
        end else if (store_temp_to_output) begin
            m_data <= temp_data;
            m_last <= temp_last;
            m_user <= temp_user;
        end
        if (store_int_to_temp) begin
            temp_data <= m_data_int;
            temp_last <= m_last_int;
            temp_user <= m_user_int;
        end
    end

endmodule

`default_nettype wire

//--- verilog/eth_fcs_insert.sv
// Pads short frames with zero bytes up to the Ethernet minimum and appends the
// CRC-32 frame check sequence, lsb first. Input ready drops while pad and FCS
// bytes are sent. Output uses the same register plus skid structure as the framer.

`timescale 1ns/10ps
`default_nettype none

module eth_fcs_insert (
    input  wire                        clk,
    input  wire                        rst,

    input  wire eth_tx_pkg::eth_byte_t s_data,
    input  wire                        s_valid,
    output logic                       s_ready,
    input  wire                        s_last,
    input  wire                        s_user,

    output eth_tx_pkg::eth_byte_t      m_data,
    output logic                       m_valid,
    input  wire                        m_ready,
    output logic                       m_last,
    output logic                       m_user
);

    eth_tx_pkg::fcs_state_t state, state_next;

    // bytes sent so far in this frame, saturates at the minimum length
    logic [5:0] frame_cnt, frame_cnt_next;
    logic [5:0] cnt_inc;
    logic [1:0] fcs_ptr, fcs_ptr_next;

    eth_tx_pkg::crc_t crc_reg, crc_next;
    eth_tx_pkg::crc_t fcs_word;

    logic s_ready_next;
    logic store_user;
    logic user_reg;

    eth_tx_pkg::eth_byte_t m_data_int;
    logic m_valid_int;
    logic m_last_int;
    logic m_user_int;
    logic m_ready_int_reg;
    logic m_ready_int_early;

    eth_tx_pkg::eth_byte_t temp_data;
    logic temp_valid, temp_valid_next;
    logic temp_last;
    logic temp_user;
    logic m_valid_next;

    logic store_int_to_output;
    logic store_int_to_temp;
    logic store_temp_to_output;

    // one byte of the reflected CRC, lsb of the data first
    function automatic eth_tx_pkg::crc_t crc_update(input eth_tx_pkg::crc_t crc_in,
                                                    input eth_tx_pkg::eth_byte_t data);
        eth_tx_pkg::crc_t crc;
        crc = crc_in ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            crc = crc[0] ? ((crc >> 1) ^ eth_tx_pkg::CRC_POLY) : (crc >> 1);
        end
        return crc;
    endfunction

    assign fcs_word = ~crc_reg;
    assign cnt_inc = (frame_cnt < 6'(eth_tx_pkg::MIN_FRAME_LEN)) ? frame_cnt + 6'd1 : frame_cnt;

    always_comb begin
        state_next = state;
        frame_cnt_next = frame_cnt;
        fcs_ptr_next = fcs_ptr;
        crc_next = crc_reg;
        s_ready_next = 1'b0;
        store_user = 1'b0;

        m_data_int = '0;
        m_valid_int = 1'b0;
        m_last_int = 1'b0;
        m_user_int = 1'b0;

        case (state)
            eth_tx_pkg::ST_PAYLOAD: begin
                s_ready_next = m_ready_int_early;
                m_data_int = s_data;
                m_valid_int = s_valid && s_ready;
                if (s_valid && s_ready) begin
                    crc_next = crc_update(crc_reg, s_data);
                    frame_cnt_next = cnt_inc;
                    if (s_last) begin
                        store_user = 1'b1;
                        s_ready_next = 1'b0;
                        // this byte brings the count to frame_cnt + 1
                        if (frame_cnt < 6'(eth_tx_pkg::MIN_FRAME_LEN - 1)) begin
                            state_next = eth_tx_pkg::ST_PAD;
                        end else begin
                            state_next = eth_tx_pkg::ST_FCS;
                        end
                    end
                end
            end
            eth_tx_pkg::ST_PAD: begin
                if (m_ready_int_reg) begin
                    m_valid_int = 1'b1;
                    crc_next = crc_update(crc_reg, 8'h00);
                    frame_cnt_next = cnt_inc;
                    if (frame_cnt == 6'(eth_tx_pkg::MIN_FRAME_LEN - 1)) begin
                        state_next = eth_tx_pkg::ST_FCS;
                    end
                end
            end
            eth_tx_pkg::ST_FCS: begin
                if (m_ready_int_reg) begin
                    m_valid_int = 1'b1;
                    m_data_int = fcs_word[8*fcs_ptr +: 8];
                    fcs_ptr_next = fcs_ptr + 2'd1;
                    if (fcs_ptr == 2'(eth_tx_pkg::FCS_LEN - 1)) begin
                        m_last_int = 1'b1;
                        m_user_int = user_reg;
                        crc_next = eth_tx_pkg::CRC_INIT;
                        frame_cnt_next = '0;
                        s_ready_next = m_ready_int_early;
                        state_next = eth_tx_pkg::ST_PAYLOAD;
                    end
                end
            end
            default: begin
                state_next = eth_tx_pkg::ST_PAYLOAD;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= eth_tx_pkg::ST_PAYLOAD;
            frame_cnt <= '0;
            fcs_ptr <= '0;
            crc_reg <= eth_tx_pkg::CRC_INIT;
            s_ready <= 1'b0;
        end else begin
            state <= state_next;
            frame_cnt <= frame_cnt_next;
            fcs_ptr <= fcs_ptr_next;
            crc_reg <= crc_next;
            s_ready <= s_ready_next;
        end
    end

    // error flag of the frame, taken from its last input byte
    always_ff @(posedge clk) begin
        if (store_user) begin
            user_reg <= s_user;
        end
    end

    assign m_ready_int_early = m_ready || (!temp_valid && (!m_valid || !m_valid_int));

    always_comb begin
        m_valid_next = m_valid;
        temp_valid_next = temp_valid;
        store_int_to_output = 1'b0;
        store_int_to_temp = 1'b0;
        store_temp_to_output = 1'b0;

        if (m_ready_int_reg) begin
            if (m_ready || !m_valid) begin
                m_valid_next = m_valid_int;
                store_int_to_output = 1'b1;
            end else begin
                temp_valid_next = m_valid_int;
                store_int_to_temp = 1'b1;
            end
        end else if (m_ready) begin
            // drain the skid register
            m_valid_next = temp_valid;
            temp_valid_next = 1'b0;
            store_temp_to_output = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid <= 1'b0;
            temp_valid <= 1'b0;
            m_ready_int_reg <= 1'b0;
        end else begin
            m_valid <= m_valid_next;
            temp_valid <= temp_valid_next;
            m_ready_int_reg <= m_ready_int_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_int_to_output) begin
            m_data <= m_data_int;
            m_last <= m_last_int;
            m_user <= m_user_int;
        end else if (store_temp_to_output) begin
            m_data <= temp_data;
            m_last <= temp_last;
            m_user <= temp_user;
        end
        if (store_int_to_temp) begin
            temp_data <= m_data_int;
            temp_last <= m_last_int;
            temp_user <= m_user_int;
        end
    end

endmodule

`default_nettype wire

//--- verilog/eth_tx_top.sv
// Transmit path top level. Header framer feeds the pad and FCS inserter,
// output is a complete frame byte stream without preamble.

`timescale 1ns/10ps
`default_nettype none

module eth_tx_top (
    input  wire                        clk,
    input  wire                        rst,

    input  wire                        hdr_valid,
    output logic                       hdr_ready,
    input  wire eth_tx_pkg::mac_addr_t dest_mac,
    input  wire eth_tx_pkg::mac_addr_t src_mac,
    input  wire eth_tx_pkg::eth_type_t eth_type,

    input  wire eth_tx_pkg::eth_byte_t pay_data,
    input  wire                        pay_valid,
    output logic                       pay_ready,
    input  wire                        pay_last,
    input  wire                        pay_user,

    output eth_tx_pkg::eth_byte_t      m_data,
    output logic                       m_valid,
    input  wire                        m_ready,
    output logic                       m_last,
    output logic                       m_user,

    output logic                       busy
);

    // framer to inserter stream
    eth_tx_pkg::eth_byte_t fr_data;
    logic fr_valid;
    logic fr_ready;
    logic fr_last;
    logic fr_user;

    eth_axis_tx u_eth_axis_tx (
        .clk       (clk),
        .rst       (rst),
        .hdr_valid (hdr_valid),
        .hdr_ready (hdr_ready),
        .dest_mac  (dest_mac),
        .src_mac   (src_mac),
        .eth_type  (eth_type),
        .pay_data  (pay_data),
        .pay_valid (pay_valid),
        .pay_ready (pay_ready),
        .pay_last  (pay_last),
        .pay_user  (pay_user),
        .m_data    (fr_data),
        .m_valid   (fr_valid),
        .m_ready   (fr_ready),
        .m_last    (fr_last),
        .m_user    (fr_user),
        .busy      (busy)
    );

    eth_fcs_insert u_eth_fcs_insert (
        .clk     (clk),
        .rst     (rst),
        .s_data  (fr_data),
        .s_valid (fr_valid),
        .s_ready (fr_ready),
        .s_last  (fr_last),
        .s_user  (fr_user),
        .m_data  (m_data),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_last  (m_last),
        .m_user  (m_user)
    );

endmodule

`default_nettype wire

//--- testbench/eth_tx_checker.sv
// Concurrent assertions for the transmit path, attached to the top level
// with bind. Covers output handshake stability and reset behavior.

`timescale 1ns/10ps
`default_nettype none

module eth_tx_checker (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        hdr_ready,
    input  wire                        m_valid,
    input  wire                        m_ready,
    input  wire eth_tx_pkg::eth_byte_t m_data,
    input  wire eth_tx_pkg::tx_state_t fr_state
);

    // number of assertion failures, read by the testbench summary
    int assert_fails = 0;

    // a stalled output byte stays put until it is taken
    property data_held_while_stalled;
        @(posedge clk) disable iff (rst)
            (m_valid && !m_ready) |=> (m_valid && $stable(m_data));
    endproperty

    // registers are cleared by the reset edge
    property quiet_after_reset;
        @(posedge clk) rst |=> (!hdr_ready && !m_valid);
    endproperty

    // no new header while the framer is still busy with a frame
    property hdr_blocked_mid_frame;
        @(posedge clk) disable iff (rst)
            (fr_state != eth_tx_pkg::TX_IDLE) |-> !hdr_ready;
    endproperty

    assert property (data_held_while_stalled)
        else begin
            $error("m_data or m_valid changed while the output was stalled");
            assert_fails++;
        end

    assert property (quiet_after_reset)
        else begin
            $error("hdr_ready or m_valid high during reset");
            assert_fails++;
        end

    assert property (hdr_blocked_mid_frame)
        else begin
            $error("hdr_ready high while a frame is in progress");
            assert_fails++;
        end

endmodule

bind eth_tx_top eth_tx_checker u_eth_tx_checker (
    .clk       (clk),
    .rst       (rst),
    .hdr_ready (hdr_ready),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .m_data    (m_data),
    .fr_state  (u_eth_axis_tx.state)
);

`default_nettype wire

//--- testbench/eth_tx_monitor.sv
// Watches the DUT output stream and status. The testbench loads each test
// with start_test; every output byte is compared with the expected frame.

`timescale 1ns/10ps
`default_nettype none

module eth_tx_monitor (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        hdr_valid,
    input  wire                        hdr_ready,
    input  wire                        pay_valid,
    input  wire                        pay_ready,
    input  wire                        pay_last,
    input  wire                        busy,
    input  wire eth_tx_pkg::eth_byte_t m_data,
    input  wire                        m_valid,
    input  wire                        m_ready,
    input  wire                        m_last,
    input  wire                        m_user
);

    logic [8*24-1:0] test_name;
    eth_tx_pkg::eth_byte_t exp_bytes[$];
    logic exp_user;
    eth_tx_pkg::crc_t exp_residue;
    eth_tx_pkg::crc_t rx_crc;
    logic exp_busy;
    logic active = 1'b0;
    int byte_idx;
    int test_errors;
    int done_count = 0;
    int pass_count = 0;
    int fail_count = 0;

    // bit serial CRC-32, lsb of each byte first
    function automatic eth_tx_pkg::crc_t crc_step(input eth_tx_pkg::crc_t c,
                                                  input eth_tx_pkg::eth_byte_t b);
        eth_tx_pkg::crc_t r;
        logic fb;
        r = c;
        for (int i = 0; i < 8; i++) begin
            fb = r[0] ^ b[i];
            r = r >> 1;
            if (fb) begin
                r = r ^ 32'hEDB8_8320;
            end
        end
        return r;
    endfunction

    task automatic start_test(input logic [8*24-1:0] name, input eth_tx_pkg::mac_addr_t dest,
                              input eth_tx_pkg::mac_addr_t src, input eth_tx_pkg::eth_type_t etype,
                              input int len, input eth_tx_pkg::eth_byte_t first,
                              input logic user, input eth_tx_pkg::crc_t residue);
        eth_tx_pkg::crc_t crc;
        exp_bytes.delete();
        for (int i = 0; i < 6; i++) begin
            exp_bytes.push_back(dest[47-8*i -: 8]);
        end
        for (int i = 0; i < 6; i++) begin
            exp_bytes.push_back(src[47-8*i -: 8]);
        end
        exp_bytes.push_back(etype[15:8]);
        exp_bytes.push_back(etype[7:0]);
        for (int i = 0; i < len; i++) begin
            exp_bytes.push_back(8'(first + i));
        end
        while (exp_bytes.size() < eth_tx_pkg::MIN_FRAME_LEN) begin
            exp_bytes.push_back(8'h00);
        end
        crc = eth_tx_pkg::CRC_INIT;
        foreach (exp_bytes[i]) begin
            crc = crc_step(crc, exp_bytes[i]);
        end
        crc = ~crc;
        for (int i = 0; i < eth_tx_pkg::FCS_LEN; i++) begin
            exp_bytes.push_back(crc[8*i +: 8]);
        end
        test_name = name;
        exp_user = user;
        exp_residue = residue;
        rx_crc = eth_tx_pkg::CRC_INIT;
        byte_idx = 0;
        test_errors = 0;
        active = 1'b1;
    endtask

    task automatic close_test();
        if (m_user !== exp_user) begin
            $display("FAILED %0s m_user: expected %b, actual %b", test_name, exp_user, m_user);
            test_errors++;
        end
        if (rx_crc !== exp_residue) begin
            $display("FAILED %0s residue: expected %h, actual %h", test_name, exp_residue, rx_crc);
            test_errors++;
        end
        if (byte_idx != exp_bytes.size() - 1) begin
            $display("FAILED %0s frame length: expected %0d, actual %0d", test_name,
                     exp_bytes.size(), byte_idx + 1);
            test_errors++;
        end
        if (test_errors == 0) begin
            $display("PASS %0s (%0d bytes)", test_name, exp_bytes.size());
            pass_count++;
        end else begin
            $display("test %0s finished with %0d errors", test_name, test_errors);
            fail_count++;
        end
        active = 1'b0;
        done_count++;
    endtask

    task automatic check_byte();
        logic last_exp;
        if (!active) begin
            $display("output byte %h arrived while no frame was expected", m_data);
            fail_count++;
        end else begin
            last_exp = (byte_idx == exp_bytes.size() - 1);
            if (m_data !== exp_bytes[byte_idx]) begin
                $display("FAILED %0s byte %0d: expected %h, actual %h", test_name, byte_idx,
                         exp_bytes[byte_idx], m_data);
                test_errors++;
            end
            if (m_last !== last_exp) begin
                $display("FAILED %0s m_last at byte %0d: expected %b, actual %b", test_name,
                         byte_idx, last_exp, m_last);
                test_errors++;
            end
            rx_crc = crc_step(rx_crc, m_data);
            if (last_exp || m_last) begin
                close_test();
            end else begin
                byte_idx++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            exp_busy <= 1'b0;
        end else begin
            if (busy !== exp_busy) begin
                $display("FAILED %0s busy: expected %b, actual %b", test_name, exp_busy,
                         busy);
                if (active) begin
                    test_errors++;
                end else begin
                    fail_count++;
                end
            end
            if (hdr_valid && hdr_ready) begin
                exp_busy <= 1'b1;
            end else if (pay_valid && pay_ready && pay_last) begin
                exp_busy <= 1'b0;
            end
            if (m_valid && m_ready) begin
                check_byte();
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/eth_tx_tb.sv
// Testbench for the transmit path. Reads the test table from the stimulus
// file, drives header and payload with random gaps and output stalls.

`timescale 1ns/10ps
`default_nettype none

module eth_tx_tb;

    localparam int MAX_TESTS = 16;

    logic clk;
    logic rst;
    logic hdr_valid;
    logic hdr_ready;
    eth_tx_pkg::mac_addr_t dest_mac;
    eth_tx_pkg::mac_addr_t src_mac;
    eth_tx_pkg::eth_type_t eth_type;
    eth_tx_pkg::eth_byte_t pay_data;
    logic pay_valid;
    logic pay_ready;
    logic pay_last;
    logic pay_user;
    eth_tx_pkg::eth_byte_t m_data;
    logic m_valid;
    logic m_ready;
    logic m_last;
    logic m_user;
    logic busy;

    integer seed;
    int stall_pct;
    int num_tests;
    int watchdog_cycles;
    logic loaded;
    logic read_ok;

    // test table
    logic [8*24-1:0] t_name [MAX_TESTS];
    eth_tx_pkg::mac_addr_t t_dest [MAX_TESTS];
    eth_tx_pkg::mac_addr_t t_src [MAX_TESTS];
    eth_tx_pkg::eth_type_t t_type [MAX_TESTS];
    int t_len [MAX_TESTS];
    eth_tx_pkg::eth_byte_t t_first [MAX_TESTS];
    logic t_user [MAX_TESTS];
    int t_stall [MAX_TESTS];
    eth_tx_pkg::crc_t t_residue [MAX_TESTS];

    always #20 clk = ~clk;

    eth_tx_top u_eth_tx_top (
        .clk(clk), .rst(rst),
        .hdr_valid(hdr_valid), .hdr_ready(hdr_ready),
        .dest_mac(dest_mac), .src_mac(src_mac), .eth_type(eth_type),
        .pay_data(pay_data), .pay_valid(pay_valid), .pay_ready(pay_ready),
        .pay_last(pay_last), .pay_user(pay_user),
        .m_data(m_data), .m_valid(m_valid), .m_ready(m_ready),
        .m_last(m_last), .m_user(m_user), .busy(busy)
    );

    eth_tx_monitor u_eth_tx_monitor (
        .clk(clk), .rst(rst),
        .hdr_valid(hdr_valid), .hdr_ready(hdr_ready),
        .pay_valid(pay_valid), .pay_ready(pay_ready), .pay_last(pay_last),
        .busy(busy), .m_data(m_data), .m_valid(m_valid), .m_ready(m_ready),
        .m_last(m_last), .m_user(m_user)
    );

    function automatic int roll_percent();
        return (($random(seed) & 32'h7fff_ffff) % 100);
    endfunction

    // output back-pressure
    always @(negedge clk) begin
        if (rst) begin
            m_ready = 1'b0;
        end else begin
            m_ready = (roll_percent() >= stall_pct);
        end
    end

    task automatic read_stimulus(output logic ok);
        integer fd;
        integer n;
        logic [8*200-1:0] line;
        ok = 1'b0;
        num_tests = 0;
        fd = $fopen("testbench/eth_tx_stimulus.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                line = '0;
                n = $fgets(line, fd);
                n = $sscanf(line, "%s %h %h %h %d %h %d %d %h", t_name[num_tests],
                            t_dest[num_tests], t_src[num_tests], t_type[num_tests],
                            t_len[num_tests], t_first[num_tests], t_user[num_tests],
                            t_stall[num_tests], t_residue[num_tests]);
                // comment and blank lines do not give all nine fields
                if (n == 9) begin
                    num_tests++;
                end
            end
            $fclose(fd);
            ok = (num_tests > 0);
        end
    endtask

    task automatic drive_header(input int t);
        logic accepted;
        @(negedge clk);
        hdr_valid = 1'b1;
        dest_mac = t_dest[t];
        src_mac = t_src[t];
        eth_type = t_type[t];
        accepted = 1'b0;
        while (!accepted) begin
            accepted = hdr_ready;
            @(negedge clk);
        end
        hdr_valid = 1'b0;
    endtask

    task automatic drive_payload(input int t);
        logic accepted;
        for (int i = 0; i < t_len[t]; i++) begin
            // idle cycles ahead of the byte
            while (stall_pct > 0 && roll_percent() < stall_pct / 2) begin
                @(negedge clk);
            end
            pay_valid = 1'b1;
            pay_data = 8'(t_first[t] + i);
            pay_last = (i == t_len[t] - 1);
            pay_user = t_user[t] && (i == t_len[t] - 1);
            accepted = 1'b0;
            while (!accepted) begin
                accepted = pay_ready;
                @(negedge clk);
            end
            pay_valid = 1'b0;
            pay_last = 1'b0;
            pay_user = 1'b0;
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        hdr_valid = 1'b0;
        dest_mac = '0;
        src_mac = '0;
        eth_type = '0;
        pay_data = '0;
        pay_valid = 1'b0;
        pay_last = 1'b0;
        pay_user = 1'b0;
        m_ready = 1'b0;
        seed = 32'h649c;
        stall_pct = 0;
        loaded = 1'b0;
        read_stimulus(read_ok);
        if (!read_ok) begin
            $display("could not read any test from the stimulus file");
            $display("tests failed");
            $finish;
        end else begin
            watchdog_cycles = 20;
            for (int t = 0; t < num_tests; t++) begin
                watchdog_cycles += 200 + 100 * t_stall[t];
            end
            loaded = 1'b1;
            repeat (3) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            for (int t = 0; t < num_tests; t++) begin
                stall_pct = t_stall[t];
                u_eth_tx_monitor.start_test(t_name[t], t_dest[t], t_src[t], t_type[t],
                                            t_len[t], t_first[t], t_user[t], t_residue[t]);
                drive_header(t);
                drive_payload(t);
                wait (u_eth_tx_monitor.done_count == t + 1);
                @(negedge clk);
            end
            $display("%0d tests run, %0d passed, %0d failed, %0d assertion failures",
                     num_tests, u_eth_tx_monitor.pass_count, u_eth_tx_monitor.fail_count,
                     u_eth_tx_top.u_eth_tx_checker.assert_fails);
            if (u_eth_tx_monitor.fail_count == 0 &&
                u_eth_tx_monitor.pass_count == num_tests &&
                u_eth_tx_top.u_eth_tx_checker.assert_fails == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

    // watchdog sized from the test table
    initial begin
        wait (loaded);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout after %0d cycles, frames stopped arriving", watchdog_cycles);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/eth_tx_stimulus.txt
# test name, dest, src, type, payload length, first payload byte, user, stall percent, residue
# residue is the CRC register after the whole frame and its FCS, without final inversion
hdr_order      0a1b2c3d4e5f 102030405060 0800 46  00 0 0  debb20e3
pass_through   ffffffffffff 020000000001 86dd 100 10 0 0  debb20e3
pad_short      001122334455 66778899aabb 0806 10  a0 0 0  debb20e3
stall_long     ffffffffffff 020000000001 86dd 100 10 0 50 debb20e3
stall_short    001122334455 66778899aabb 0806 10  a0 0 50 debb20e3
user_flag      5e0000000001 0200deadbeef 88b5 20  40 1 20 debb20e3
user_long      010203040506 0708090a0b0c 0800 80  f0 1 0  debb20e3
one_pad_byte   a1a2a3a4a5a6 b1b2b3b4b5b6 9000 45  7f 0 30 debb20e3
one_byte       c0c1c2c3c4c5 d0d1d2d3d4d5 0842 1   55 0 10 debb20e3

//--- sim.f
common/eth_tx_pkg.sv
eth_axis_tx/eth_axis_tx.sv
verilog/eth_fcs_insert.sv
verilog/eth_tx_top.sv
testbench/eth_tx_checker.sv
testbench/eth_tx_monitor.sv
testbench/eth_tx_tb.sv

//--- Bender.yml
package:
  name: eth_tx

sources:
  - common/eth_tx_pkg.sv
  - eth_axis_tx/eth_axis_tx.sv
  - verilog/eth_fcs_insert.sv
  - verilog/eth_tx_top.sv
  - target: simulation
    files:
      - testbench/eth_tx_checker.sv
      - testbench/eth_tx_monitor.sv
      - testbench/eth_tx_tb.sv
